// ==== verilog.f ====
roce_tx_pkg.sv
payload_beat_counter.sv
qp_tx_state.sv
dma_tx_ctrl.sv
roce_dma_tx_top.sv
tb_roce_dma_tx_assert.sv
tb_roce_dma_tx.sv

// ==== Makefile ====
TOP := tb_roce_dma_tx

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q -e "Errors found" -e "%Error" sim.log; then \
	  echo "simulation FAILED"; exit 1; \
	elif ! grep -q "No errors" sim.log; then \
	  echo "simulation ended without a result"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== tb_roce_dma_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_roce_dma_tx;

  import roce_tx_pkg::*;

  localparam int MSG_COUNT_WIDTH = 16;
  // the tests stream a little over 2000 cycles, so about twice that
  localparam int TIMEOUT_CYCLES = 4000;

  logic                       clk;
  logic                       rst;
  logic                       start;
  logic                       stop;
  byte_len_t                  dma_length;
  psn_t                       rem_psn;
  vaddr_t                     rem_addr;
  logic [MSG_COUNT_WIDTH-1:0] n_transfers;
  pmtu_t                      pmtu;
  logic                       payload_tready = 1'b1;
  logic                       desc_valid;
  psn_t                       desc_psn;
  vaddr_t                     desc_addr;
  byte_len_t                  desc_length;
  data_t                      payload_tdata;
  keep_t                      payload_tkeep;
  logic                       payload_tvalid;
  logic                       payload_tlast;
  logic                       busy;
  logic                       done;

  // model of the running test
  string       test_name;
  byte_len_t   exp_len;
  psn_t        exp_psn;
  vaddr_t      exp_addr;
  pmtu_t       exp_pmtu;
  int          msg_base;
  int          pay_base;
  int          desc_total = 0;
  int          msg_total = 0;
  int          beat_idx = 0;
  int          mon_errors = 0;
  int          seq_errors = 0;
  int          cycle_count = 0;
  logic        random_ready = 1'b0;
  logic [31:0] lcg_state = 32'd77479;

  roce_dma_tx_top #(.MSG_COUNT_WIDTH(MSG_COUNT_WIDTH)) dut_i (.*);

  bind roce_dma_tx_top tb_roce_dma_tx_assert assert_i (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .dma_length     (dma_length),
    .desc_valid     (desc_valid),
    .payload_tdata  (payload_tdata),
    .payload_tkeep  (payload_tkeep),
    .payload_tvalid (payload_tvalid),
    .payload_tready (payload_tready),
    .payload_tlast  (payload_tlast),
    .busy           (busy),
    .done           (done)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // packets per message, unknown pmtu counts as 4096
  function automatic longint packets(input byte_len_t len, input pmtu_t mtu);
    longint eff;
    eff = 4096;
    if (mtu == 13'd256 || mtu == 13'd512 || mtu == 13'd1024 || mtu == 13'd2048) begin
      eff = longint'(mtu);
    end
    return (longint'(len) + eff - 1) / eff;
  endfunction

  function automatic int check_value(input string field, input logic [63:0] expected,
                                     input logic [63:0] actual);
    int bad;
    bad = 0;
    assert (actual === expected) else begin
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
      bad = 1;
    end
    return bad;
  endfunction

  task automatic check_desc(input int k);
    psn_t   psn;
    vaddr_t addr;
    psn  = psn_t'(longint'(exp_psn) + longint'(k) * packets(exp_len, exp_pmtu));
    addr = exp_addr + vaddr_t'(longint'(k) * longint'(exp_len));
    mon_errors += check_value("desc psn", 64'(psn), 64'(desc_psn));
    mon_errors += check_value("desc addr", addr, desc_addr);
    mon_errors += check_value("desc length", 64'(exp_len), 64'(desc_length));
  endtask

  task automatic check_beat();
    longint    nbeats;
    byte_len_t off;
    logic      last;
    keep_t     keep;
    nbeats = (longint'(exp_len) + 7) / 8;
    off    = byte_len_t'(beat_idx * 8);
    last   = longint'(beat_idx) == nbeats - 1;
    keep   = 8'hff;
    if (last && exp_len[2:0] != 3'd0) begin
      keep = keep_t'((9'd1 << exp_len[2:0]) - 9'd1);
    end
    mon_errors += check_value("tdata", {~off, off}, payload_tdata);
    mon_errors += check_value("tkeep", 64'(keep), 64'(payload_tkeep));
    mon_errors += check_value("tlast", 64'(last), 64'(payload_tlast));
    if (last) begin
      beat_idx  = 0;
      msg_total = msg_total + 1;
    end else begin
      beat_idx = beat_idx + 1;
    end
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic launch(input string name, input byte_len_t len, input psn_t psn,
                        input vaddr_t addr, input logic [MSG_COUNT_WIDTH-1:0] count,
                        input pmtu_t mtu);
    test_name   = name;
    exp_len     = len;
    exp_psn     = psn;
    exp_addr    = addr;
    exp_pmtu    = mtu;
    msg_base    = desc_total;
    pay_base    = msg_total;
    dma_length  = len;
    rem_psn     = psn;
    rem_addr    = addr;
    n_transfers = count;
    pmtu        = mtu;
    pulse_start();
  endtask

  task automatic wait_done();
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = done;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_count(input int expected);
    seq_errors += check_value("message count", 64'(expected), 64'(desc_total - msg_base));
    // each message ran through to its final beat
    seq_errors += check_value("payload messages", 64'(expected), 64'(msg_total - pay_base));
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // sink ready, random only in the back-pressure test
  always @(posedge clk) begin
    #1;
    lcg_state = lcg_next(lcg_state);
    payload_tready = random_ready ? (lcg_state[31:30] != 2'b00) : 1'b1;
  end

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && desc_valid) begin
      check_desc(desc_total - msg_base);
      desc_total = desc_total + 1;
    end
    if (!rst && payload_tvalid && payload_tready) begin
      check_beat();
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    rst         = 1'b1;
    start       = 1'b0;
    stop        = 1'b0;
    dma_length  = '0;
    rem_psn     = '0;
    rem_addr    = '0;
    n_transfers = '0;
    pmtu        = '0;
    test_name   = "reset";
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    launch("single", 32'd64, 24'h000010, 64'h1000, 16'd1, 13'd256);
    wait_done();
    check_count(1);

    launch("three msgs", 32'd700, 24'h000100, 64'h0002_0000, 16'd3, 13'd256);
    wait_done();
    check_count(3);

    random_ready = 1'b1;
    launch("backpressure", 32'd1000, 24'h00abcd, 64'h0001_0000_0000, 16'd4, 13'd512);
    wait_done();
    check_count(4);
    random_ready = 1'b0;

    // psn and address both wrap
    launch("psn wrap", 32'd4096, 24'hffffff, 64'hffff_ffff_ffff_f800, 16'd2, 13'd4096);
    wait_done();
    check_count(2);

    launch("bad pmtu", 32'd310, 24'd100, 64'h3000, 16'd2, 13'd300);
    wait_done();
    check_count(2);

    launch("stop", 32'd128, 24'd500, 64'h4000, 16'd5, 13'd256);
    while (desc_total - msg_base < 1) @(posedge clk);
    #1;
    dma_length = 32'd8;
    rem_psn    = 24'd7;
    pulse_start();
    while (desc_total - msg_base < 2) @(posedge clk);
    repeat (3) @(posedge clk);
    #1;
    stop = 1'b1;
    @(posedge clk);
    #1;
    stop = 1'b0;
    wait_done();
    check_count(2);

    launch("zero length", 32'd0, 24'd1, 64'h5000, 16'd1, 13'd256);
    repeat (4) begin
      @(negedge clk);
      seq_errors += check_value("busy", 64'd0, 64'(busy));
    end
    check_count(0);

    $display("run complete: %0d errors", mon_errors + seq_errors);
    if (mon_errors + seq_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_roce_dma_tx_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_roce_dma_tx_assert (
  input logic                   clk,
  input logic                   rst,
  input logic                   start,
  input roce_tx_pkg::byte_len_t dma_length,
  input logic                   desc_valid,
  input roce_tx_pkg::data_t     payload_tdata,
  input roce_tx_pkg::keep_t     payload_tkeep,
  input logic                   payload_tvalid,
  input logic                   payload_tready,
  input logic                   payload_tlast,
  input logic                   busy,
  input logic                   done
);

  logic start_ok;
  logic last_beat;

  // start the controller has to take
  assign start_ok  = start & ~busy & ~done & (dma_length != '0);
  assign last_beat = payload_tvalid & payload_tready & payload_tlast;

  a_reset_idle: assert property (@(posedge clk)
    rst |=> !busy && !done && !desc_valid && !payload_tvalid)
    else $error("outputs active after reset");

  a_start_busy: assert property (@(posedge clk) disable iff (rst)
    start_ok |=> busy)
    else $error("busy not raised one cycle after start");

  a_start_desc: assert property (@(posedge clk) disable iff (rst)
    $past(start_ok) |=> desc_valid && payload_tvalid)
    else $error("first descriptor and beat not two cycles after start");

  a_zero_start: assert property (@(posedge clk) disable iff (rst)
    start && !busy && !done && (dma_length == '0) |=> !busy)
    else $error("zero length start made the generator busy");

  // stalled beat holds its contents
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    payload_tvalid && !payload_tready |=> payload_tvalid && $stable(payload_tdata)
      && $stable(payload_tkeep) && $stable(payload_tlast))
    else $error("payload changed while stalled");

  a_end_outcome: assert property (@(posedge clk) disable iff (rst)
    last_beat |=> (done ^ busy) && !desc_valid && !payload_tvalid)
    else $error("cycle after the last beat is neither done nor a gap");

  a_next_desc: assert property (@(posedge clk) disable iff (rst)
    $past(last_beat) && !done |=> desc_valid)
    else $error("next descriptor not two cycles after the last beat");

  a_done_idle: assert property (@(posedge clk) disable iff (rst)
    done |-> !busy && !desc_valid && !payload_tvalid)
    else $error("done while still active");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done)
    else $error("done longer than one cycle");

  a_desc_pulse: assert property (@(posedge clk) disable iff (rst)
    desc_valid |=> !desc_valid)
    else $error("desc_valid longer than one cycle");

endmodule

`default_nettype wire

// ==== roce_dma_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module roce_dma_tx_top #(
  parameter int MSG_COUNT_WIDTH = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  input  logic                         stop,
  input  roce_tx_pkg::byte_len_t       dma_length,
  input  roce_tx_pkg::psn_t            rem_psn,
  input  roce_tx_pkg::vaddr_t          rem_addr,
  input  logic [MSG_COUNT_WIDTH-1:0]   n_transfers,
  input  roce_tx_pkg::pmtu_t           pmtu,
  output logic                         desc_valid,
  output roce_tx_pkg::psn_t            desc_psn,
  output roce_tx_pkg::vaddr_t          desc_addr,
  output roce_tx_pkg::byte_len_t       desc_length,
  output roce_tx_pkg::data_t           payload_tdata,
  output roce_tx_pkg::keep_t           payload_tkeep,
  output logic                         payload_tvalid,
  input  logic                         payload_tready,
  output logic                         payload_tlast,
  output logic                         busy,
  output logic                         done
);

  logic capture;
  logic advance;
  logic beat_load;
  logic last_msg;
  logic msg_end;

  dma_tx_ctrl ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .stop       (stop),
    .dma_length (dma_length),
    .last_msg   (last_msg),
    .msg_end    (msg_end),
    .capture    (capture),
    .desc_valid (desc_valid),
    .beat_load  (beat_load),
    .advance    (advance),
    .busy       (busy),
    .done       (done)
  );

  // queue pair registers, also the source of the descriptor fields
  qp_tx_state #(
    .MSG_COUNT_WIDTH (MSG_COUNT_WIDTH)
  ) qp_i (
    .clk         (clk),
    .rst         (rst),
    .capture     (capture),
    .advance     (advance),
    .dma_length  (dma_length),
    .rem_psn     (rem_psn),
    .rem_addr    (rem_addr),
    .n_transfers (n_transfers),
    .pmtu        (pmtu),
    .psn         (desc_psn),
    .addr        (desc_addr),
    .length      (desc_length),
    .last_msg    (last_msg)
  );

  // payload length follows the captured length
  payload_beat_counter beat_i (
    .clk       (clk),
    .rst       (rst),
    .beat_load (beat_load),
    .length    (desc_length),
    .tdata     (payload_tdata),
    .tkeep     (payload_tkeep),
    .tvalid    (payload_tvalid),
    .tready    (payload_tready),
    .tlast     (payload_tlast),
    .msg_end   (msg_end)
  );

endmodule

`default_nettype wire

// ==== dma_tx_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_tx_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   stop,
  input  roce_tx_pkg::byte_len_t dma_length,
  input  logic                   last_msg,
  input  logic                   msg_end,
  output logic                   capture,
  output logic                   desc_valid,
  output logic                   beat_load,
  output logic                   advance,
  output logic                   busy,
  output logic                   done
);

  // st_advance is the first cycle of a follow-on message,
  // st_finish streams the message that ends the sequence
  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_stream,
    st_advance,
    st_finish
  } tx_state_t;

  tx_state_t state_q;
  tx_state_t state_d;
  logic      stop_q;
  logic      issue_q;
  logic      issue_d;
  logic      final_msg;

  assign final_msg = last_msg | stop_q;

  always_comb begin
    state_d = state_q;
    capture = 1'b0;
    advance = 1'b0;
    done    = 1'b0;
    issue_d = 1'b0;
    case (state_q)
      st_idle: begin
        // zero length start is dropped
        if (start && (dma_length != '0)) begin
          capture = 1'b1;
          state_d = st_load;
        end
      end
      st_load: begin
        issue_d = 1'b1;
        state_d = st_stream;
      end
      st_stream: begin
        if (msg_end) begin
          if (final_msg) begin
            done    = 1'b1;
            state_d = st_idle;
          end else begin
            // step psn and address in time for the next descriptor
            advance = 1'b1;
            issue_d = 1'b1;
            state_d = st_advance;
          end
        end else if (final_msg) begin
          state_d = st_finish;
        end
      end
      st_advance: begin
        state_d = final_msg ? st_finish : st_stream;
      end
      st_finish: begin
        if (msg_end) begin
          done    = 1'b1;
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      issue_q <= 1'b0;
      stop_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      issue_q <= issue_d;
      if (done) begin
        stop_q <= 1'b0;
      end else if (stop && (state_q != st_idle)) begin
        stop_q <= 1'b1;
      end
    end
  end

  // descriptor and first beat go out together
  assign desc_valid = issue_q;
  assign beat_load  = issue_q;

  // drops in the cycle done pulses
  assign busy = (state_q != st_idle) & ~done;

endmodule

`default_nettype wire

// ==== qp_tx_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module qp_tx_state #(
  parameter int MSG_COUNT_WIDTH = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       capture,
  input  logic                       advance,
  input  roce_tx_pkg::byte_len_t     dma_length,
  input  roce_tx_pkg::psn_t          rem_psn,
  input  roce_tx_pkg::vaddr_t        rem_addr,
  input  logic [MSG_COUNT_WIDTH-1:0] n_transfers,
  input  roce_tx_pkg::pmtu_t         pmtu,
  output roce_tx_pkg::psn_t          psn,
  output roce_tx_pkg::vaddr_t        addr,
  output roce_tx_pkg::byte_len_t     length,
  output logic                       last_msg
);

  import roce_tx_pkg::*;

  logic [3:0]                 shift_d;
  logic [11:0]                mask_d;
  logic [3:0]                 shift_q;
  logic [11:0]                mask_q;
  byte_len_t                  len_q;
  byte_len_t                  off_q;
  byte_len_t                  pkt_count;
  psn_t                       psn_q;
  vaddr_t                     base_q;
  logic [MSG_COUNT_WIDTH-1:0] sent_q;
  logic [MSG_COUNT_WIDTH-1:0] last_idx_q;

  // unsupported pmtu values fall back to 4096
  always_comb begin
    case (pmtu)
      13'd256: begin
        shift_d = 4'd8;
        mask_d  = 12'h0ff;
      end
      13'd512: begin
        shift_d = 4'd9;
        mask_d  = 12'h1ff;
      end
      13'd1024: begin
        shift_d = 4'd10;
        mask_d  = 12'h3ff;
      end
      13'd2048: begin
        shift_d = 4'd11;
        mask_d  = 12'h7ff;
      end
      default: begin
        shift_d = 4'd12;
        mask_d  = 12'hfff;
      end
    endcase
  end

  // packets per message, rounded up
  assign pkt_count = (len_q >> shift_q) + {31'd0, |(len_q[11:0] & mask_q)};

  always_ff @(posedge clk) begin
    if (capture) begin
      len_q   <= dma_length;
      psn_q   <= rem_psn;
      base_q  <= rem_addr;
      off_q   <= '0;
      shift_q <= shift_d;
      mask_q  <= mask_d;
    end else if (advance) begin
      psn_q <= psn_q + pkt_count[$bits(psn_t)-1:0];
      off_q <= off_q + len_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sent_q     <= '0;
      last_idx_q <= '0;
    end else if (capture) begin
      sent_q <= '0;
      // zero transfers runs one message
      if (n_transfers == '0) begin
        last_idx_q <= '0;
      end else begin
        last_idx_q <= n_transfers - MSG_COUNT_WIDTH'(1);
      end
    end else if (advance) begin
      sent_q <= sent_q + MSG_COUNT_WIDTH'(1);
    end
  end

  assign psn      = psn_q;
  assign addr     = base_q + vaddr_t'(off_q);
  assign length   = len_q;
  assign last_msg = sent_q == last_idx_q;

endmodule

`default_nettype wire

// ==== payload_beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_beat_counter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   beat_load,
  input  roce_tx_pkg::byte_len_t length,
  output roce_tx_pkg::data_t     tdata,
  output roce_tx_pkg::keep_t     tkeep,
  output logic                   tvalid,
  input  logic                   tready,
  output logic                   tlast,
  output logic                   msg_end
);

  import roce_tx_pkg::*;

  byte_len_t                 offset_q;
  logic                      active_q;
  logic                      msg_end_q;
  logic                      handshake;
  logic [32:0]               next_offset;
  logic [BEAT_BYTE_BITS-1:0] tail;
  keep_t                     tail_keep;

  // valid already in the load cycle
  assign tvalid    = active_q | beat_load;
  assign handshake = tvalid & tready;

  // 33 bits so a length near 2^32 cannot wrap the compare
  assign next_offset = {1'b0, offset_q} + {1'b0, BYTES_PER_BEAT};
  assign tlast       = next_offset >= {1'b0, length};

  assign tail      = length[BEAT_BYTE_BITS-1:0];
  assign tail_keep = ~(KEEP_FULL << tail);
  assign tkeep     = (tlast && (tail != '0)) ? tail_keep : KEEP_FULL;

  // counting word in the low half, its inverse above
  assign tdata = {~offset_q, offset_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      offset_q  <= '0;
      active_q  <= 1'b0;
      msg_end_q <= 1'b0;
    end else begin
      msg_end_q <= handshake & tlast;
      if (handshake) begin
        if (tlast) begin
          offset_q <= '0;
          active_q <= 1'b0;
        end else begin
          offset_q <= offset_q + BYTES_PER_BEAT;
          active_q <= 1'b1;
        end
      end else if (beat_load) begin
        offset_q <= '0;
        active_q <= 1'b1;
      end
    end
  end

  assign msg_end = msg_end_q;

endmodule

`default_nettype wire

// ==== roce_tx_pkg.sv ====
`default_nettype none

package roce_tx_pkg;

  // byte count of a dma transfer, also used for address offsets
  typedef logic [31:0] byte_len_t;

  // packet sequence number, wraps at 2^24
  typedef logic [23:0] psn_t;

  // remote virtual address
  typedef logic [63:0] vaddr_t;

  // path mtu in bytes
  typedef logic [12:0] pmtu_t;

  // one payload word and its byte enables
  typedef logic [63:0] data_t;
  typedef logic [7:0]  keep_t;

  // bytes carried by one payload beat
  parameter byte_len_t BYTES_PER_BEAT = 32'd8;

  // low length bits that select the byte lane within a beat
  parameter int BEAT_BYTE_BITS = 3;

  // all byte lanes enabled
  parameter keep_t KEEP_FULL = 8'hff;

endpackage

`default_nettype wire
